//--- logic/core_pkg.sv
package core_pkg;

	// Datapath and address width
	localparam int XLEN = 64;

	// Reorder buffer size and index with one wrap bit
	localparam int ROB_SIZE  = 32;
	localparam int ROB_IDX_W = $clog2(ROB_SIZE) + 1;

	// Physical register file
	localparam int PRF_SIZE  = 64;
	localparam int PRF_TAG_W = $clog2(PRF_SIZE);

	// One common data bus, result of a functional unit
	typedef struct packed {
		logic                 valid;	// Broadcast this cycle
		logic [PRF_TAG_W-1:0] tag;		// Physical destination register
		logic [XLEN-1:0]      data;		// Result value
	} cdb_t;

endpackage

//--- logic/lq_pkg.sv
package lq_pkg;

	import core_pkg::*;

	localparam int LQ_DEPTH = 8;
	localparam int LQ_IDX_W = $clog2(LQ_DEPTH);

	// One dispatch slot from rename
	typedef struct packed {
		logic                 valid;
		logic [XLEN-1:0]      pc;
		logic [31:0]          inst;
		logic [XLEN-1:0]      opa;			// Base, always data
		logic [XLEN-1:0]      opb;			// Offset, or tag in the low bits
		logic                 opb_valid;	// Low while opb is still a tag
		logic [ROB_IDX_W-1:0] rob_idx;
		logic [PRF_TAG_W-1:0] dest_tag;
	} lq_dispatch_t;

	// What one entry shows to the selection logic
	typedef struct packed {
		logic                 inuse;
		logic                 addr_valid;
		logic                 requested;	// Memory read already sent
		logic                 value_valid;	// Memory data has come back
		logic [XLEN-1:0]      pc;
		logic [31:0]          inst;
		logic [XLEN-1:0]      opa;
		logic [XLEN-1:0]      opb;
		logic [ROB_IDX_W-1:0] rob_idx;
		logic [PRF_TAG_W-1:0] dest_tag;
		logic [XLEN-1:0]      value;
	} lq_entry_t;

	typedef struct packed {
		logic                valid;
		logic [LQ_IDX_W-1:0] idx;
		logic [XLEN-1:0]     addr;
	} mem_req_t;

	typedef struct packed {
		logic                valid;
		logic [LQ_IDX_W-1:0] idx;	// Entry that issued the read
		logic [XLEN-1:0]     data;
	} mem_resp_t;

	typedef struct packed {
		logic                 valid;
		logic [ROB_IDX_W-1:0] rob_idx;
		logic [PRF_TAG_W-1:0] dest_tag;
		logic [XLEN-1:0]      pc;
		logic [XLEN-1:0]      value;
	} lq_complete_t;

endpackage

//--- logic/lq_entry.sv
`timescale 1ns/1ns

module lq_entry (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      clean,
	input  logic                      free_enable,
	input  logic                      load,
	input  lq_pkg::lq_dispatch_t      dispatch,
	input  core_pkg::cdb_t            cdb1,
	input  core_pkg::cdb_t            cdb2,
	input  logic                      request_grant,
	input  logic                      mem_data_valid,
	input  logic [core_pkg::XLEN-1:0] mem_data,
	output lq_pkg::lq_entry_t         state,
	output logic                      available
);

	import core_pkg::*;
	import lq_pkg::*;

	logic                 inuse;
	logic                 addr_valid;
	logic                 requested;
	logic                 value_valid;
	logic [XLEN-1:0]      pc;
	logic [31:0]          inst;
	logic [XLEN-1:0]      opa;
	logic [XLEN-1:0]      opb;
	logic [ROB_IDX_W-1:0] rob_idx;
	logic [PRF_TAG_W-1:0] dest_tag;
	logic [XLEN-1:0]      value;

	logic                 holding;
	logic [XLEN-1:0]      src_opb;
	logic                 src_valid;
	logic                 wake1;
	logic                 wake2;
	logic [XLEN-1:0]      next_opb;
	logic                 next_addr_valid;
	logic                 capture;

	// A tag broadcast in the dispatch cycle is caught as well
	always_comb begin
		holding         = load | inuse;
		src_opb         = load ? dispatch.opb : opb;
		src_valid       = load ? dispatch.opb_valid : addr_valid;
		wake1           = holding && !src_valid && cdb1.valid
			&& (src_opb[PRF_TAG_W-1:0] == cdb1.tag);
		wake2           = holding && !src_valid && cdb2.valid
			&& (src_opb[PRF_TAG_W-1:0] == cdb2.tag);
		next_opb        = src_opb;
		next_addr_valid = src_valid;
		if (wake1) begin
			next_opb        = cdb1.data;	// cdb1 has priority
			next_addr_valid = 1'b1;
		end else if (wake2) begin
			next_opb        = cdb2.data;
			next_addr_valid = 1'b1;
		end
	end

	// Only a read this entry has issued may fill it
	assign capture = mem_data_valid && inuse && requested && !value_valid && !load;

	always_ff @(posedge clock) begin
		if (reset || clean) begin
			inuse       <= 1'b0;
			addr_valid  <= 1'b0;
			requested   <= 1'b0;
			value_valid <= 1'b0;
		end else if (load) begin
			inuse       <= 1'b1;	// Refill wins over free
			addr_valid  <= next_addr_valid;
			requested   <= 1'b0;
			value_valid <= 1'b0;
		end else begin
			if (free_enable)
				inuse <= 1'b0;
			addr_valid <= next_addr_valid;
			if (request_grant)
				requested <= 1'b1;
			if (capture)
				value_valid <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (load) begin
			pc       <= dispatch.pc;
			inst     <= dispatch.inst;
			opa      <= dispatch.opa;
			rob_idx  <= dispatch.rob_idx;
			dest_tag <= dispatch.dest_tag;
		end
		opb <= next_opb;
		if (capture)
			value <= mem_data;
	end

	// Free now, or leaving at this edge after completion
	assign available = !inuse || free_enable;

	always_comb begin
		state.inuse       = inuse;
		state.addr_valid  = addr_valid;
		state.requested   = requested;
		state.value_valid = value_valid;
		state.pc          = pc;
		state.inst        = inst;
		state.opa         = opa;
		state.opb         = opb;
		state.rob_idx     = rob_idx;
		state.dest_tag    = dest_tag;
		state.value       = value;
	end

endmodule

//--- logic/lq_alloc.sv
`timescale 1ns/1ns

module lq_alloc (
	input  logic [lq_pkg::LQ_DEPTH-1:0] inuse,
	input  lq_pkg::lq_dispatch_t        dispatch1,
	input  lq_pkg::lq_dispatch_t        dispatch2,
	output logic [lq_pkg::LQ_DEPTH-1:0] load,
	output logic [lq_pkg::LQ_DEPTH-1:0] dispatch_sel,
	output logic                        space1,
	output logic                        space2
);

	import lq_pkg::*;

	logic                first_found;
	logic                second_found;
	logic [LQ_IDX_W-1:0] first_idx;
	logic [LQ_IDX_W-1:0] second_idx;
	logic [LQ_IDX_W:0]   free_count;

	// Two lowest free indices and the number of free entries
	always_comb begin
		first_found  = 1'b0;
		second_found = 1'b0;
		first_idx    = '0;
		second_idx   = '0;
		free_count   = '0;
		for (int i = 0; i < LQ_DEPTH; i++) begin
			if (!inuse[i]) begin
				free_count = free_count + 1'b1;
				if (!first_found) begin
					first_found = 1'b1;
					first_idx   = LQ_IDX_W'(i);
				end else if (!second_found) begin
					second_found = 1'b1;
					second_idx   = LQ_IDX_W'(i);
				end
			end
		end
	end

	// dispatch_sel high means the entry takes slot 2
	always_comb begin
		load         = '0;
		dispatch_sel = '0;
		if (dispatch1.valid && first_found)
			load[first_idx] = 1'b1;
		if (dispatch2.valid) begin
			if (dispatch1.valid) begin
				if (second_found) begin
					load[second_idx]         = 1'b1;
					dispatch_sel[second_idx] = 1'b1;
				end
			end else if (first_found) begin
				load[first_idx]         = 1'b1;	// Lone slot 2 takes the lowest
				dispatch_sel[first_idx] = 1'b1;
			end
		end
	end

	assign space1 = (free_count != '0);
	assign space2 = (free_count > (LQ_IDX_W + 1)'(1));

endmodule

//--- logic/lq_mem_select.sv
`timescale 1ns/1ns

module lq_mem_select (
	input  logic                        clock,
	input  logic                        reset,
	input  logic                        clean,
	input  lq_pkg::lq_entry_t           states [lq_pkg::LQ_DEPTH],
	output logic [lq_pkg::LQ_DEPTH-1:0] request_grant,
	output lq_pkg::mem_req_t            mem_req,
	output logic [lq_pkg::LQ_DEPTH-1:0] free_enable,
	output lq_pkg::lq_complete_t        complete
);

	import core_pkg::*;
	import lq_pkg::*;

	logic                req_found;
	logic [LQ_IDX_W-1:0] req_idx;
	logic [XLEN-1:0]     req_addr;
	logic                done_found;
	logic [LQ_IDX_W-1:0] done_idx;

	// Lowest-index priority for both pickers
	always_comb begin
		req_found  = 1'b0;
		req_idx    = '0;
		done_found = 1'b0;
		done_idx   = '0;
		for (int i = 0; i < LQ_DEPTH; i++) begin
			if (!req_found && states[i].inuse && states[i].addr_valid
				&& !states[i].requested) begin
				req_found = 1'b1;
				req_idx   = LQ_IDX_W'(i);
			end
			if (!done_found && states[i].inuse && states[i].addr_valid
				&& states[i].value_valid) begin
				done_found = 1'b1;
				done_idx   = LQ_IDX_W'(i);
			end
		end
	end

	assign req_addr = states[req_idx].opa + states[req_idx].opb;	// Base plus offset

	always_comb begin
		request_grant = '0;
		if (req_found)
			request_grant[req_idx] = 1'b1;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			mem_req.valid <= 1'b0;
		end else begin
			mem_req.valid <= req_found && !clean;	// Pending read dropped on clean
			if (req_found) begin
				mem_req.idx  <= req_idx;
				mem_req.addr <= req_addr;
			end
		end
	end

	// A load flushed this cycle is not written back
	always_comb begin
		complete.valid    = done_found && !clean;
		complete.rob_idx  = states[done_idx].rob_idx;
		complete.dest_tag = states[done_idx].dest_tag;
		complete.pc       = states[done_idx].pc;
		complete.value    = states[done_idx].value;
		free_enable       = '0;
		if (complete.valid)
			free_enable[done_idx] = 1'b1;
	end

endmodule

//--- logic/load_queue.sv
`timescale 1ns/1ns

module load_queue (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 clean,
	input  lq_pkg::lq_dispatch_t dispatch1,
	input  lq_pkg::lq_dispatch_t dispatch2,
	input  core_pkg::cdb_t       cdb1,
	input  core_pkg::cdb_t       cdb2,
	input  lq_pkg::mem_resp_t    mem_resp,
	output logic                 space1,
	output logic                 space2,
	output lq_pkg::mem_req_t     mem_req,
	output lq_pkg::lq_complete_t complete
);

	import lq_pkg::*;

	lq_entry_t           states [LQ_DEPTH];
	lq_dispatch_t        entry_dispatch [LQ_DEPTH];
	logic [LQ_DEPTH-1:0] available;
	logic [LQ_DEPTH-1:0] occupied;
	logic [LQ_DEPTH-1:0] load;
	logic [LQ_DEPTH-1:0] dispatch_sel;
	logic [LQ_DEPTH-1:0] request_grant;
	logic [LQ_DEPTH-1:0] free_enable;
	logic [LQ_DEPTH-1:0] mem_data_valid;

	// An entry completing this cycle can be refilled at the same edge
	assign occupied = ~available;

	generate
		for (genvar i = 0; i < LQ_DEPTH; i++) begin : g_entry
			assign mem_data_valid[i] = mem_resp.valid && (mem_resp.idx == LQ_IDX_W'(i));
			assign entry_dispatch[i] = dispatch_sel[i] ? dispatch2 : dispatch1;

			lq_entry i_entry (
				.clock          (clock),
				.reset          (reset),
				.clean          (clean),
				.free_enable    (free_enable[i]),
				.load           (load[i]),
				.dispatch       (entry_dispatch[i]),
				.cdb1           (cdb1),
				.cdb2           (cdb2),
				.request_grant  (request_grant[i]),
				.mem_data_valid (mem_data_valid[i]),
				.mem_data       (mem_resp.data),
				.state          (states[i]),
				.available      (available[i])
			);
		end
	endgenerate

	lq_alloc i_alloc (
		.inuse        (occupied),
		.dispatch1    (dispatch1),
		.dispatch2    (dispatch2),
		.load         (load),
		.dispatch_sel (dispatch_sel),
		.space1       (space1),
		.space2       (space2)
	);

	lq_mem_select i_select (
		.clock         (clock),
		.reset         (reset),
		.clean         (clean),
		.states        (states),
		.request_grant (request_grant),
		.mem_req       (mem_req),
		.free_enable   (free_enable),
		.complete      (complete)
	);

endmodule

//--- sim/load_queue_assertions.sv
`timescale 1ns/1ns

module load_queue_assertions (
	input logic                        clock,
	input logic                        reset,
	input lq_pkg::lq_dispatch_t        dispatch1,
	input lq_pkg::lq_dispatch_t        dispatch2,
	input logic                        space1,
	input logic                        space2,
	input lq_pkg::mem_req_t            mem_req,
	input lq_pkg::lq_complete_t        complete,
	input lq_pkg::lq_entry_t           states [lq_pkg::LQ_DEPTH],
	input logic [lq_pkg::LQ_DEPTH-1:0] free_enable
);

	import lq_pkg::*;

	logic [LQ_DEPTH-1:0] inuse_vec;
	logic [LQ_DEPTH-1:0] value_vec;
	int                  error_count = 0;

	always_comb begin
		for (int i = 0; i < LQ_DEPTH; i++) begin
			inuse_vec[i] = states[i].inuse;
			value_vec[i] = states[i].value_valid;
		end
	end

	// A request is a one-cycle strobe per entry
	assert property (@(posedge clock) disable iff (reset)
		mem_req.valid |=> !(mem_req.valid && mem_req.idx == $past(mem_req.idx)))
		else begin
			$error("memory request repeated for the same entry");
			error_count++;
		end

	// A completed entry is released, or refilled without a value
	assert property (@(posedge clock) disable iff (reset)
		complete.valid |=> !(|($past(free_enable) & inuse_vec & value_vec)))
		else begin
			$error("completed entry still in use with its value");
			error_count++;
		end

	assert property (@(posedge clock) disable iff (reset) dispatch2.valid |-> space2)
		else begin
			$error("second dispatch slot used without room for two");
			error_count++;
		end

	assert property (@(posedge clock) disable iff (reset) dispatch1.valid |-> space1)
		else begin
			$error("dispatch into a full queue");
			error_count++;
		end

endmodule

bind load_queue load_queue_assertions i_assertions (
	.clock       (clock),
	.reset       (reset),
	.dispatch1   (dispatch1),
	.dispatch2   (dispatch2),
	.space1      (space1),
	.space2      (space2),
	.mem_req     (mem_req),
	.complete    (complete),
	.states      (states),
	.free_enable (free_enable)
);

//--- sim/load_queue_tb.sv
`timescale 1ns/1ns

module load_queue_tb;

	import core_pkg::*;
	import lq_pkg::*;

	localparam logic [XLEN-1:0] MEM_KEY = 64'h5a5a_c3c3_0f0f_9696;
	localparam int MAX_ROWS = 32;

	logic         clock;
	logic         reset;
	logic         clean;
	lq_dispatch_t dispatch1;
	lq_dispatch_t dispatch2;
	cdb_t         cdb1;
	cdb_t         cdb2;
	mem_resp_t    mem_resp;
	logic         space1;
	logic         space2;
	mem_req_t     mem_req;
	lq_complete_t complete;

	// Stimulus table, one load per row
	logic [XLEN-1:0] t_base [MAX_ROWS];
	logic [XLEN-1:0] t_opb [MAX_ROWS];
	logic [XLEN-1:0] t_data [MAX_ROWS];	// Bus data for tag loads
	bit              t_pair [MAX_ROWS];	// Dispatched together with the next row
	bit              t_opb_valid [MAX_ROWS];
	int              t_delay [MAX_ROWS];
	int              t_bus [MAX_ROWS];
	int              t_action [MAX_ROWS];	// 1 full check, 2 drain first, 3 clean after
	int              rows;

	// Scoreboard keyed by rob_idx
	bit              exp_live [1 << ROB_IDX_W];
	logic [XLEN-1:0] exp_value [1 << ROB_IDX_W];
	logic [XLEN-1:0] exp_pc [1 << ROB_IDX_W];
	logic [PRF_TAG_W-1:0] exp_dest [1 << ROB_IDX_W];
	int              live_count;
	int              bc_due [MAX_ROWS];
	int              cycles;
	int              limit;

	int              pend_due [$];
	logic [LQ_IDX_W-1:0] pend_idx [$];
	logic [XLEN-1:0] pend_addr [$];

	load_queue i_dut (
		.clock     (clock),
		.reset     (reset),
		.clean     (clean),
		.dispatch1 (dispatch1),
		.dispatch2 (dispatch2),
		.cdb1      (cdb1),
		.cdb2      (cdb2),
		.mem_resp  (mem_resp),
		.space1    (space1),
		.space2    (space2),
		.mem_req   (mem_req),
		.complete  (complete)
	);

	always #10 clock = ~clock;

	task automatic check(input string name, input logic [XLEN-1:0] got,
		input logic [XLEN-1:0] exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			$display("Simulation finished: FAIL");
			$fatal(1);
		end
	endtask

	task automatic add_row(input bit pair, input logic [XLEN-1:0] base,
		input logic [XLEN-1:0] opb, input bit opb_valid, input int delay, input int bus,
		input logic [XLEN-1:0] data, input int action);
		t_pair[rows]      = pair;
		t_base[rows]      = base;
		t_opb[rows]       = opb;
		t_opb_valid[rows] = opb_valid;
		t_delay[rows]     = delay;
		t_bus[rows]       = bus;
		t_data[rows]      = data;
		t_action[rows]    = action;
		bc_due[rows]      = -1;
		rows++;
	endtask

	// Builds the slot and records the expected completion
	function automatic lq_dispatch_t issue_row(input int n);
		lq_dispatch_t d;
		logic [XLEN-1:0] offset;
		d.valid     = 1'b1;
		d.pc        = 64'h4000 + XLEN'(n * 4);
		d.inst      = 32'h0003_3003;
		d.opa       = t_base[n];
		d.opb       = t_opb[n];
		d.opb_valid = t_opb_valid[n];
		d.rob_idx   = ROB_IDX_W'(n);
		d.dest_tag  = PRF_TAG_W'(n + 8);
		offset      = t_opb_valid[n] ? t_opb[n] : t_data[n];
		exp_live[n]  = 1'b1;
		exp_value[n] = (t_base[n] + offset) ^ MEM_KEY;
		exp_pc[n]    = d.pc;
		exp_dest[n]  = d.dest_tag;
		live_count++;
		if (!t_opb_valid[n])
			bc_due[n] = cycles + t_delay[n];
		return d;
	endfunction

	// Completion monitor, memory model and bus driver share one process
	always @(posedge clock) begin
		cycles++;
		if (cycles > limit) begin
			$display("Timeout: loads never completed after %0d cycles", cycles);
			$display("Simulation finished: FAIL");
			$fatal(1);
		end
		if (!reset && complete.valid) begin
			if (!exp_live[complete.rob_idx]) begin
				$display("Unexpected completion for rob_idx %0d at %0t",
					complete.rob_idx, $time);
				$display("Simulation finished: FAIL");
				$fatal(1);
			end
			check("complete.value", complete.value, exp_value[complete.rob_idx]);
			check("complete.pc", complete.pc, exp_pc[complete.rob_idx]);
			check("complete.dest_tag", XLEN'(complete.dest_tag),
				XLEN'(exp_dest[complete.rob_idx]));
			exp_live[complete.rob_idx] = 1'b0;
			live_count--;
		end
		if (!reset && mem_req.valid) begin
			pend_due.push_back(cycles + $urandom_range(1, 6));
			pend_idx.push_back(mem_req.idx);
			pend_addr.push_back(mem_req.addr);
		end
		#2;
		if (i_dut.i_assertions.error_count != 0) begin
			$display("Assertion failed in the load queue checker at %0t", $time);
			$display("Simulation finished: FAIL");
			$fatal(1);
		end
		mem_resp = '0;
		foreach (pend_due[k]) begin
			if (pend_due[k] <= cycles) begin
				mem_resp.valid = 1'b1;
				mem_resp.idx   = pend_idx[k];
				mem_resp.data  = pend_addr[k] ^ MEM_KEY;
				pend_due.delete(k);
				pend_idx.delete(k);
				pend_addr.delete(k);
				break;
			end
		end
		cdb1 = '0;
		cdb2 = '0;
		for (int n = 0; n < rows; n++) begin
			if (bc_due[n] == cycles) begin
				if (t_bus[n] == 1)
					cdb1 = '{valid: 1'b1, tag: t_opb[n][PRF_TAG_W-1:0], data: t_data[n]};
				else
					cdb2 = '{valid: 1'b1, tag: t_opb[n][PRF_TAG_W-1:0], data: t_data[n]};
			end
		end
	end

	initial begin
		int n;
		int first;
		void'($urandom(32'h8d73_f82c));
		clock = 1'b0;
		reset = 1'b1;
		clean = 1'b0;
		dispatch1 = '0;
		dispatch2 = '0;
		cdb1 = '0;
		cdb2 = '0;
		mem_resp = '0;
		cycles = 0;
		rows = 0;
		live_count = 0;
		limit = 1000000;
		add_row(0, 64'h1000, 64'h20, 1, 0, 0, 0, 0);
		add_row(1, 64'h2000, 64'h8, 1, 0, 0, 0, 0);
		add_row(0, 64'h2100, 64'h10, 1, 0, 0, 0, 0);
		add_row(0, 64'h3000, 64'd43, 0, 5, 1, 64'h40, 0);	// Wakeup on cdb1
		add_row(0, 64'h3100, 64'd44, 0, 3, 2, 64'h80, 0);	// Wakeup on cdb2
		for (int i = 0; i < 8; i++)
			add_row(i % 2 == 0, 64'h5000 + 64'(i * 256), 64'(45 + i), 0, 30 + i,
				1 + i % 2, 64'(i * 24), (i == 7) ? 1 : 0);
		add_row(1, 64'h6000, 64'h18, 1, 0, 0, 0, 0);
		add_row(0, 64'h6200, 64'h28, 1, 0, 0, 0, 0);
		for (int i = 0; i < 6; i++)
			add_row(i % 2 == 0, 64'h9000 + 64'(i * 64), 64'(20 + i), 0, 60,
				1 + i % 2, 64'(i * 8), (i == 0) ? 2 : 0);	// Still waiting at the clean
		add_row(1, 64'h7000, 64'h30, 1, 0, 0, 0, 3);
		add_row(0, 64'h7100, 64'd58, 0, 50, 1, 64'h100, 1);
		add_row(0, 64'h8000, 64'h38, 1, 0, 0, 0, 0);
		add_row(0, 64'h8100, 64'd60, 0, 4, 2, 64'h200, 0);
		limit = 40 * rows + 200;
		repeat (3) @(posedge clock);
		#2;
		reset = 1'b0;
		check("mem_req.valid", XLEN'(mem_req.valid), 0);
		check("complete.valid", XLEN'(complete.valid), 0);
		check("space1", XLEN'(space1), 1);
		check("space2", XLEN'(space2), 1);
		n = 0;
		while (n < rows) begin
			if (t_action[n] == 2) begin
				while (live_count != 0)
					@(posedge clock);
			end
			forever begin
				@(posedge clock);
				#2;
				dispatch1 = '0;
				dispatch2 = '0;
				if (t_pair[n] ? space2 : space1)
					break;
			end
			first = n;
			dispatch1 = issue_row(n);
			if (t_pair[n]) begin
				dispatch2 = issue_row(n + 1);
				n++;
			end
			@(posedge clock);
			#2;
			dispatch1 = '0;
			dispatch2 = '0;
			if (t_action[n] == 1) begin
				check("space1", XLEN'(space1), 0);	// Every entry taken
				check("space2", XLEN'(space2), 0);
			end
			if (t_action[first] == 3) begin
				@(posedge clock);
				#2;
				clean = 1'b1;
				exp_live = '{default: 1'b0};
				live_count = 0;
				@(posedge clock);
				#2;
				clean = 1'b0;
				check("space2", XLEN'(space2), 1);
				repeat (8) @(posedge clock);	// Stale responses drain
			end
			n++;
		end
		while (live_count != 0)
			@(posedge clock);
		repeat (10) @(posedge clock);
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

//--- tb.f
logic/core_pkg.sv
logic/lq_pkg.sv
logic/lq_entry.sv
logic/lq_alloc.sv
logic/lq_mem_select.sv
logic/load_queue.sv
sim/load_queue_assertions.sv
sim/load_queue_tb.sv
